// ==== hdl/block_game_pkg.sv ====
`default_nettype none

package block_game_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned layer_w   = 7;
  localparam int unsigned cmd_w     = 16;
  localparam int unsigned score_w   = 8;
  localparam int unsigned pos_w     = 3;
  localparam int unsigned op_w      = 2;
  localparam int unsigned payload_w = cmd_w - op_w;

  // Opcode in the top bits of the command word
  typedef enum logic [op_w-1:0] {
    op_nop  = 2'd0,
    op_load = 2'd1,
    op_jump = 2'd2,
    op_rsvd = 2'd3
  } cmd_op_t;

  ////////////////////
  // Payload views
  ////////////////////

  // Bit i of each map belongs to cell i
  typedef struct packed {
    logic [layer_w-1:0] cell_map;
    logic [layer_w-1:0] cell_kind;
  } layer_view_t;

  // dir high steps right
  typedef struct packed {
    logic                 dir;
    logic [payload_w-2:0] pad;
  } jump_view_t;

  typedef union packed {
    layer_view_t layer;
    jump_view_t  jump;
  } cmd_payload_u;

endpackage

`default_nettype wire

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input  wire                                    clk,
  input  wire                                    arst_n,
  input  wire                                    enable,
  input  wire                                    cmd_valid,
  input  wire  [block_game_pkg::cmd_w-1:0]       cmd_word,
  output logic                                   load_stb,
  output logic                                   jump_stb,
  output logic                                   jump_dir,
  output logic [block_game_pkg::layer_w-1:0]     layer_map,
  output logic [block_game_pkg::layer_w-1:0]     layer_kind
);

  import block_game_pkg::*;

  cmd_op_t      opcode;
  cmd_payload_u payload;
  logic         cmd_fire;

  // Split the word into opcode and payload
  assign opcode   = cmd_op_t'(cmd_word[cmd_w-1 -: op_w]);
  assign payload  = cmd_word[payload_w-1:0];
  assign cmd_fire = cmd_valid && enable;

  ////////////////////
  // Strobes
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_stb <= 1'b0;
      jump_stb <= 1'b0;
    end else begin
      load_stb <= 1'b0;
      jump_stb <= 1'b0;
      if (cmd_fire) begin
        unique case (opcode)
          op_load: load_stb <= 1'b1;
          op_jump: jump_stb <= 1'b1;
          // nop and reserved words are dropped here
          default: ;
        endcase
      end
    end
  end

  // Payload fields, read through the view the opcode selects
  always_ff @(posedge clk) begin
    if (cmd_fire && opcode == op_load) begin
      layer_map  <= payload.layer.cell_map;
      layer_kind <= payload.layer.cell_kind;
    end
    if (cmd_fire && opcode == op_jump) begin
      jump_dir <= payload.jump.dir;
    end
  end

  // One command per cycle downstream
  a_one_strobe: assert property (
    @(posedge clk) disable iff (!arst_n) !(load_stb && jump_stb)
  );

endmodule

`default_nettype wire

// ==== hdl/block_field.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_field #(
  parameter int unsigned num_layers = 5,
  parameter int unsigned char_row   = 3,
  parameter int unsigned start_pos  = 3
) (
  input  wire                                    clk,
  input  wire                                    arst_n,
  input  wire                                    enable,
  input  wire                                    load_stb,
  input  wire                                    jump_stb,
  input  wire                                    jump_dir,
  input  wire  [block_game_pkg::layer_w-1:0]     layer_map,
  input  wire  [block_game_pkg::layer_w-1:0]     layer_kind,
  output logic                                   move_stb,
  output logic                                   move_fail,
  output logic [block_game_pkg::pos_w-1:0]       char_pos,
  output logic [block_game_pkg::layer_w-1:0]     row_map,
  output logic [block_game_pkg::layer_w-1:0]     row_kind,
  output logic                                   game_over
);

  import block_game_pkg::*;

  // Layer 0 is the newest, the last one drops off on a load
  logic [layer_w-1:0] map_q  [num_layers];
  logic [layer_w-1:0] kind_q [num_layers];

  logic               load_fire;
  logic               jump_fire;
  logic [pos_w:0]     target;
  logic [pos_w-1:0]   tgt_cell;
  logic               off_edge;
  logic               hazard;
  logic               step_fail;

  assign load_fire = enable && load_stb;
  assign jump_fire = enable && jump_stb && !game_over;

  ////////////////////
  // Layer field
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_layers; i++) begin
        map_q[i]  <= '0;
        kind_q[i] <= '0;
      end
    end else if (load_fire) begin
      map_q[0]  <= layer_map;
      kind_q[0] <= layer_kind;
      for (int i = 1; i < num_layers; i++) begin
        map_q[i]  <= map_q[i-1];
        kind_q[i] <= kind_q[i-1];
      end
    end
  end

  // Row under the character
  assign row_map  = map_q[char_row];
  assign row_kind = kind_q[char_row];

  ////////////////////
  // Collision check
  ////////////////////

  // One extra bit so a step left from cell 0 wraps above the field
  assign target   = jump_dir ? {1'b0, char_pos} + (pos_w+1)'(1)
                             : {1'b0, char_pos} - (pos_w+1)'(1);
  assign tgt_cell = target[pos_w-1:0];
  assign off_edge = target > (pos_w+1)'(layer_w - 1);

  // Cell only looked at when it lies inside the field
  assign hazard    = !off_edge && map_q[char_row][tgt_cell] && kind_q[char_row][tgt_cell];
  assign step_fail = off_edge || hazard;

  ////////////////////
  // Character state
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      char_pos  <= pos_w'(start_pos);
      game_over <= 1'b0;
      move_stb  <= 1'b0;
      move_fail <= 1'b0;
    end else if (!enable) begin
      char_pos  <= pos_w'(start_pos);
      game_over <= 1'b0;
      move_stb  <= 1'b0;
      move_fail <= 1'b0;
    end else begin
      move_stb <= jump_fire;
      if (jump_fire) begin
        move_fail <= step_fail;
        if (step_fail) begin
          // Position held on a failed step
          game_over <= 1'b1;
        end else begin
          char_pos <= tgt_cell;
        end
      end
    end
  end

  a_pos_in_field: assert property (
    @(posedge clk) disable iff (!arst_n) char_pos < layer_w
  );

  // No step is reported once the game has ended
  a_no_move_after_over: assert property (
    @(posedge clk) disable iff (!arst_n) move_stb |-> !$past(game_over)
  );

endmodule

`default_nettype wire

// ==== hdl/jump_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_result (
  input  wire                                    clk,
  input  wire                                    arst_n,
  input  wire                                    enable,
  input  wire                                    move_stb,
  input  wire                                    move_fail,
  input  wire  [block_game_pkg::pos_w-1:0]       char_pos,
  output logic                                   res_valid,
  output logic                                   res_fail,
  output logic [block_game_pkg::pos_w-1:0]       res_pos,
  output logic [block_game_pkg::score_w-1:0]     score
);

  import block_game_pkg::*;

  logic score_inc;

  // Successful step, held at the top of the range
  assign score_inc = move_stb && !move_fail && (score != '1);

  ////////////////////
  // Result strobe
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= enable && move_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (move_stb) begin
      res_fail <= move_fail;
      res_pos  <= char_pos;
    end
  end

  ////////////////////
  // Score
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      score <= '0;
    end else if (!enable) begin
      score <= '0;
    end else if (score_inc) begin
      score <= score + score_w'(1);
    end
  end

  a_score_monotonic: assert property (
    @(posedge clk) disable iff (!arst_n) enable |=> score >= $past(score)
  );

endmodule

`default_nettype wire

// ==== hdl/block_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_game_top #(
  parameter int unsigned num_layers = 5,
  parameter int unsigned char_row   = 3,
  parameter int unsigned start_pos  = 3
) (
  input  wire                                    clk,
  input  wire                                    arst_n,
  input  wire                                    enable,
  input  wire                                    cmd_valid,
  input  wire  [block_game_pkg::cmd_w-1:0]       cmd_word,
  output logic                                   res_valid,
  output logic                                   res_fail,
  output logic [block_game_pkg::pos_w-1:0]       res_pos,
  output logic [block_game_pkg::score_w-1:0]     score,
  output logic [block_game_pkg::layer_w-1:0]     row_map,
  output logic [block_game_pkg::layer_w-1:0]     row_kind,
  output logic                                   game_over
);

  import block_game_pkg::*;

  // Decode to execute
  logic               load_stb;
  logic               jump_stb;
  logic               jump_dir;
  logic [layer_w-1:0] layer_map;
  logic [layer_w-1:0] layer_kind;

  // Execute to result
  logic               move_stb;
  logic               move_fail;
  logic [pos_w-1:0]   char_pos;

  cmd_decode cmd_decode_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable     (enable),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .load_stb   (load_stb),
    .jump_stb   (jump_stb),
    .jump_dir   (jump_dir),
    .layer_map  (layer_map),
    .layer_kind (layer_kind)
  );

  block_field #(
    .num_layers (num_layers),
    .char_row   (char_row),
    .start_pos  (start_pos)
  ) block_field_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable     (enable),
    .load_stb   (load_stb),
    .jump_stb   (jump_stb),
    .jump_dir   (jump_dir),
    .layer_map  (layer_map),
    .layer_kind (layer_kind),
    .move_stb   (move_stb),
    .move_fail  (move_fail),
    .char_pos   (char_pos),
    .row_map    (row_map),
    .row_kind   (row_kind),
    .game_over  (game_over)
  );

  jump_result jump_result_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .move_stb  (move_stb),
    .move_fail (move_fail),
    .char_pos  (char_pos),
    .res_valid (res_valid),
    .res_fail  (res_fail),
    .res_pos   (res_pos),
    .score     (score)
  );

endmodule

`default_nettype wire

// ==== tests/block_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_game_tb;

  ////////////////////
  // Constants
  ////////////////////

  localparam int num_layers    = 5;
  localparam int char_row      = 3;
  localparam int start_pos     = 3;
  localparam int layer_w       = 7;
  localparam int clk_period    = 40;
  localparam int reset_cycles  = 10;
  localparam int n_random      = 400;
  localparam int restart_every = 32;
  // Directed part, then the random part with its gaps and restarts
  localparam int run_cycles    = reset_cycles + 200 + 3 * n_random;

  localparam logic [1:0] cmd_nop  = 2'd0;
  localparam logic [1:0] cmd_load = 2'd1;
  localparam logic [1:0] cmd_jump = 2'd2;
  localparam logic [1:0] cmd_rsvd = 2'd3;

  typedef struct packed {
    int unsigned due;
    logic        fail;
    logic [2:0]  pos;
    logic [7:0]  score;
  } result_t;

  typedef struct packed {
    int unsigned due;
    logic [6:0]  map;
    logic [6:0]  kind;
    logic        over;
  } row_chk_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        enable;
  logic        cmd_valid;
  logic [15:0] cmd_word;
  logic        res_valid;
  logic        res_fail;
  logic [2:0]  res_pos;
  logic [7:0]  score;
  logic [6:0]  row_map;
  logic [6:0]  row_kind;
  logic        game_over;

  // Reference model state
  logic [6:0]  m_map  [num_layers];
  logic [6:0]  m_kind [num_layers];
  int          m_pos;
  int          m_score;
  logic        m_over;
  logic        m_fail;

  result_t     res_q [$];
  row_chk_t    chk_q [$];
  int unsigned cycle = 0;
  integer      seed  = 98;

  block_game_top #(
    .num_layers (num_layers),
    .char_row   (char_row),
    .start_pos  (start_pos)
  ) block_game_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .res_valid (res_valid),
    .res_fail  (res_fail),
    .res_pos   (res_pos),
    .score     (score),
    .row_map   (row_map),
    .row_kind  (row_kind),
    .game_over (game_over)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Applies one command, returns 1 when it yields a step result
  function automatic logic apply_command(input logic [15:0] word);
    int target;
    apply_command = 1'b0;
    if (word[15:14] == cmd_load) begin
      for (int i = num_layers - 1; i > 0; i--) begin
        m_map[i]  = m_map[i-1];
        m_kind[i] = m_kind[i-1];
      end
      m_map[0]  = word[13:7];
      m_kind[0] = word[6:0];
    end else if (word[15:14] == cmd_jump && !m_over) begin
      target = word[13] ? m_pos + 1 : m_pos - 1;
      if (target < 0 || target >= layer_w) begin
        m_fail = 1'b1;
      end else begin
        m_fail = m_map[char_row][target] && m_kind[char_row][target];
      end
      if (m_fail) begin
        m_over = 1'b1;
      end else begin
        m_pos = target;
        if (m_score < 255) m_score = m_score + 1;
      end
      apply_command = 1'b1;
    end
  endfunction

  function automatic logic [15:0] load_word(input logic [6:0] map, input logic [6:0] kind);
    return {cmd_load, map, kind};
  endfunction

  function automatic logic [15:0] jump_word(input logic dir);
    return {cmd_jump, dir, 13'h0};
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic issue(input logic [15:0] word);
    result_t  exp_res;
    row_chk_t exp_row;
    logic     has_res;
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd_word  = word;
    has_res   = 1'b0;
    if (enable) has_res = apply_command(word);
    if (has_res) begin
      exp_res.due   = cycle + 3;
      exp_res.fail  = m_fail;
      exp_res.pos   = m_pos[2:0];
      exp_res.score = m_score[7:0];
      res_q.push_back(exp_res);
    end
    exp_row.due  = cycle + 2;
    exp_row.map  = m_map[char_row];
    exp_row.kind = m_kind[char_row];
    exp_row.over = m_over;
    chk_q.push_back(exp_row);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic set_enable(input logic en);
    // Let commands in flight drain first
    repeat (5) idle_cycle();
    enable = en;
    if (!en) begin
      m_pos   = start_pos;
      m_over  = 1'b0;
      m_score = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (game_over === 1'b0 && score === 8'd0)
        else abort_run($sformatf("[ERROR] %0t: game_over=%b score=%0d with enable low",
                                 $time, game_over, score));
    end
  endtask

  // Result and row comparison
  always @(negedge clk) begin
    result_t  exp_res;
    row_chk_t exp_row;
    if (arst_n) begin
      if (res_valid) begin
        if (res_q.size() == 0) begin
          abort_run("A result came out with no command waiting for one");
        end else begin
          exp_res = res_q.pop_front();
          assert (cycle == exp_res.due && res_fail === exp_res.fail &&
                  res_pos === exp_res.pos && score === exp_res.score)
            else abort_run($sformatf(
              "[ERROR] %0t: fail=%b pos=%0d score=%0d, expected fail=%b pos=%0d score=%0d",
              $time, res_fail, res_pos, score, exp_res.fail, exp_res.pos, exp_res.score));
        end
      end else if (res_q.size() != 0 && res_q[0].due < cycle) begin
        abort_run("An expected step result never arrived");
      end
      if (chk_q.size() != 0 && chk_q[0].due == cycle) begin
        exp_row = chk_q.pop_front();
        assert (row_map === exp_row.map && row_kind === exp_row.kind &&
                game_over === exp_row.over)
          else abort_run($sformatf(
            "[ERROR] %0t: row %b/%b over=%b, expected %b/%b over=%b", $time,
            row_map, row_kind, game_over, exp_row.map, exp_row.kind, exp_row.over));
      end
    end
  end

  initial begin
    integer rnd;
    arst_n    = 1'b0;
    enable    = 1'b1;
    cmd_valid = 1'b0;
    cmd_word  = 16'h0;
    for (int i = 0; i < num_layers; i++) begin
      m_map[i]  = 7'h0;
      m_kind[i] = 7'h0;
    end
    m_pos   = start_pos;
    m_score = 0;
    m_over  = 1'b0;
    m_fail  = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    arst_n = 1'b1;

    repeat (5) idle_cycle();
    @(negedge clk);
    assert (res_valid === 1'b0 && score === 8'd0 && game_over === 1'b0 &&
            row_map === 7'h0 && row_kind === 7'h0)
      else abort_run($sformatf("[ERROR] %0t: outputs not idle after reset", $time));

    // Fill the field, then one more load moves the row on
    issue(load_word(7'b0110110, 7'b0000000));
    issue(load_word(7'b1111111, 7'b0000001));
    issue(load_word(7'b1000001, 7'b1000001));
    issue(load_word(7'b0011100, 7'b0001000));
    issue(load_word(7'b0000000, 7'b1111111));

    // Back-to-back steps over safe blocks, then onto the hazard at cell 0
    repeat (2) issue(jump_word(1'b1));
    repeat (5) issue(jump_word(1'b0));
    issue(jump_word(1'b1));
    issue(load_word(7'b0101010, 7'b0010100));

    // Commands with enable low are ignored
    set_enable(1'b0);
    issue(load_word(7'b1111111, 7'b1111111));
    issue(jump_word(1'b1));
    set_enable(1'b1);
    issue({cmd_nop, 14'h3fff});
    issue({cmd_rsvd, 14'h2a55});

    // Off the right edge, then off the left edge
    issue(load_word(7'b0011100, 7'b0001000));
    repeat (4) issue(jump_word(1'b1));
    set_enable(1'b0);
    set_enable(1'b1);
    repeat (4) issue(jump_word(1'b0));

    ////////////////////
    // Random run
    ////////////////////

    for (int n = 0; n < n_random; n++) begin
      if (n % restart_every == 0) begin
        set_enable(1'b0);
        set_enable(1'b1);
      end
      rnd = $random(seed);
      if (rnd[31:30] == 2'b00) idle_cycle();
      issue(rnd[15:0]);
    end
    repeat (8) idle_cycle();

    if (res_q.size() == 0 && chk_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("Expected results were left unmatched at the end of the run");
    end
  end

  // Watchdog
  initial begin
    #((run_cycles + 50) * clk_period);
    abort_run("Timeout: the run did not finish in the expected time");
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/block_game_pkg.sv
hdl/cmd_decode.sv
hdl/block_field.sv
hdl/jump_result.sv
hdl/block_game_top.sv
tests/block_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the block game testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module block_game_tb -f build.f -o block_game_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/block_game_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q ">>> FAIL" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q ">>> PASS" "$log"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
exit 0
